// File: flist.f
source/mmu_pkg.sv
source/mmu_ctrl_pkg.sv
source/find_first_set.sv
source/tlb.sv
source/page_table_ram.sv
source/page_walker.sv
source/xlate_ctrl.sv
source/mmu_top.sv
verif/mmu_chk.sv
verif/mmu_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mmu_tb
FLIST    = flist.f
BUILD    = obj_dir
LOG      = sim.log
RUN_OPTS = +verilator+error+limit+10

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	-./$(BUILD)/V$(TOP) $(RUN_OPTS) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: verif/mmu_tb.sv
`timescale 1ns/10ps

module mmu_tb;

   localparam int REQ_DEPTH    = 4;
   localparam int RESP_CREDITS = 2;
   localparam int TLB_N        = 4;
   localparam int N_BURST      = 40;
   localparam int N_REQ        = 16 + N_BURST;
   localparam int CYCLE_LIMIT  = 40 * N_REQ + 200;

   typedef struct packed {
      logic                     hit;
      logic                     fault;
      logic [mmu_pkg::VA_W-1:0] pa;
   } xlate_t;

   logic                      clk;
   logic                      rst_n;
   logic                      active;
   logic                      flush;
   logic                      req_valid;
   logic [mmu_pkg::VA_W-1:0]  req_va;
   logic                      req_store;
   logic                      req_credit;
   logic                      resp_valid;
   logic [mmu_pkg::VA_W-1:0]  resp_pa;
   logic                      resp_fault;
   logic                      resp_hit;
   logic                      resp_credit;
   logic                      pt_we;
   logic [5:0]                pt_index;
   mmu_pkg::pte_t             pt_entry;

   mmu_pkg::pte_t             shadow_pt [64];
   logic                      tlb_v [TLB_N];
   logic [mmu_pkg::VPN_W-1:0] tlb_tag [TLB_N];
   mmu_pkg::pte_t             tlb_pte [TLB_N];
   int                        tlb_rr;
   xlate_t                    exp_q [$];
   string                     name_q [$];
   string                     test_name;
   int                        req_cred;
   int                        resp_cred;
   int                        owed;
   int                        cycles;
   logic                      late;

   mmu_top dut0 (
      .clk         (clk),
      .rst_n       (rst_n),
      .active      (active),
      .flush       (flush),
      .req_valid   (req_valid),
      .req_va      (req_va),
      .req_store   (req_store),
      .req_credit  (req_credit),
      .resp_valid  (resp_valid),
      .resp_pa     (resp_pa),
      .resp_fault  (resp_fault),
      .resp_hit    (resp_hit),
      .resp_credit (resp_credit),
      .pt_we       (pt_we),
      .pt_index    (pt_index),
      .pt_entry    (pt_entry)
   );

   bind xlate_ctrl mmu_chk #(.RESP_CREDITS(RESP_CREDITS)) u_chk (
      .clk         (clk),
      .rst_n       (rst_n),
      .req_valid   (req_valid),
      .req_credit  (req_credit),
      .resp_valid  (resp_valid),
      .resp_credit (resp_credit),
      .walk_start  (walk_start),
      .walk_done   (walk_done)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #20 clk = ~clk;
      end
   end

   task automatic report_error(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   function automatic int checker_errors();
      return dut0.u_ctrl.u_chk.credit_errs + dut0.u_ctrl.u_chk.queue_errs
             + dut0.u_ctrl.u_chk.walk_errs;
   endfunction

   // ppn mixes the whole index and a few entries are invalid or lack a permission.
   function automatic mmu_pkg::pte_t make_pte(input int i);
      mmu_pkg::pte_t e;
      e            = '0;
      e.valid      = (i % 13) != 1;
      e.dirty      = i[0];
      e.readable   = (i % 7) != 3;
      e.writable   = (i % 5) != 2;
      e.executable = i[1];
      e.user       = i[2];
      e.ppn        = 28'(i * 32'h0012_3457) ^ 28'h5a3_c000;
      return e;
   endfunction

   function automatic logic [mmu_pkg::VA_W-1:0] make_va(input int vpn, input int ofs);
      return {24'($urandom), 28'(vpn), 12'(ofs)};
   endfunction

   // computes the expected response and advances the TLB model as the DUT would.
   function automatic xlate_t expect_xlate(input logic [mmu_pkg::VA_W-1:0] va,
                                           input logic st);
      xlate_t                    r;
      mmu_pkg::pte_t             e;
      logic [mmu_pkg::VPN_W-1:0] vpn;
      int                        slot;
      r    = '0;
      vpn  = va[mmu_pkg::PAGE_OFS_W +: mmu_pkg::VPN_W];
      slot = -1;
      if (!active)
      begin
         r.hit = 1'b1;
         r.pa  = va;
         return r;
      end
      for (int i = TLB_N - 1; i >= 0; i--)
      begin
         if (tlb_v[i] && (tlb_tag[i] == vpn))
         begin
            slot = i;
         end
      end
      r.hit = (slot >= 0);
      if (slot < 0)
      begin
         e = shadow_pt[vpn[5:0]];
         // invalid entries fault without a refill.
         if (!e.valid)
         begin
            r.fault = 1'b1;
            return r;
         end
         slot          = tlb_rr;
         tlb_v[slot]   = 1'b1;
         tlb_tag[slot] = vpn;
         tlb_pte[slot] = e;
         tlb_rr        = (tlb_rr + 1) % TLB_N;
      end
      e       = tlb_pte[slot];
      r.fault = st ? !e.writable : !e.readable;
      if (!r.fault)
      begin
         r.pa = {24'b0, e.ppn, va[11:0]};
      end
      return r;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #2;
      req_valid = 1'b0;
      pt_we     = 1'b0;
      flush     = 1'b0;
   endtask

   task automatic send_req(input logic [mmu_pkg::VA_W-1:0] va, input logic st);
      while (req_cred == 0)
      begin
         next_cycle();
      end
      req_valid = 1'b1;
      req_va    = va;
      req_store = st;
      req_cred--;
      exp_q.push_back(expect_xlate(va, st));
      name_q.push_back(test_name);
      next_cycle();
   endtask

   task automatic drain();
      while (exp_q.size() != 0)
      begin
         next_cycle();
      end
      repeat (2) next_cycle();
   endtask

   task automatic flush_tlb();
      flush = 1'b1;
      foreach (tlb_v[i])
      begin
         tlb_v[i] = 1'b0;
      end
      next_cycle();
   endtask

   // gives response credits back with gaps while late is set.
   initial
   begin
      int gap;
      gap         = 0;
      resp_credit = 1'b0;
      forever
      begin
         @(posedge clk);
         #2;
         resp_credit = 1'b0;
         if (gap > 0)
         begin
            gap--;
         end
         else if (owed > 0)
         begin
            resp_credit = 1'b1;
            owed--;
            gap = late ? 6 : 0;
         end
      end
   end

   always @(negedge clk)
   begin
      xlate_t want;
      string  name;
      cycles++;
      if (cycles > CYCLE_LIMIT)
      begin
         report_error($sformatf("timeout, run still busy after %0d cycles", CYCLE_LIMIT));
      end
      if (rst_n)
      begin
         assert (checker_errors() == 0)
            else report_error("protocol checker flagged a violation");
         if (req_credit)
         begin
            req_cred++;
         end
         assert (req_cred <= REQ_DEPTH)
            else report_error("more request credits returned than requests sent");
         if (resp_valid)
         begin
            assert (resp_cred > 0)
               else report_error("response sent while no response credit was held");
            assert (exp_q.size() > 0)
               else report_error("response arrived with no request outstanding");
            want = exp_q.pop_front();
            name = name_q.pop_front();
            assert (resp_hit === want.hit)
               else report_error($sformatf("MISMATCH %s hit expected %0b actual %0b",
                                           name, want.hit, resp_hit));
            assert (resp_fault === want.fault)
               else report_error($sformatf("MISMATCH %s fault expected %0b actual %0b",
                                           name, want.fault, resp_fault));
            assert (resp_pa === want.pa)
               else report_error($sformatf("MISMATCH %s pa expected %h actual %h",
                                           name, want.pa, resp_pa));
            resp_cred--;
            owed++;
         end
         if (resp_credit)
         begin
            resp_cred++;
         end
      end
   end

   initial
   begin
      int vpn;
      void'($urandom(39686));
      rst_n     = 1'b0;
      active    = 1'b1;
      flush     = 1'b0;
      req_valid = 1'b0;
      req_va    = '0;
      req_store = 1'b0;
      pt_we     = 1'b0;
      pt_index  = '0;
      pt_entry  = '0;
      req_cred  = REQ_DEPTH;
      resp_cred = RESP_CREDITS;
      owed      = 0;
      cycles    = 0;
      late      = 1'b0;
      tlb_rr    = 0;
      test_name = "reset";
      foreach (tlb_v[i])
      begin
         tlb_v[i] = 1'b0;
      end
      repeat (16) @(posedge clk);
      #2;
      rst_n = 1'b1;

      for (int i = 0; i < 64; i++)
      begin
         shadow_pt[i] = make_pte(i);
         pt_we        = 1'b1;
         pt_index     = 6'(i);
         pt_entry     = shadow_pt[i];
         next_cycle();
      end

      test_name = "miss_then_hit";
      send_req(make_va(4, 'h3a8), 1'b0);
      drain();
      send_req(make_va(4, 'h010), 1'b1);
      drain();

      // entry 1 invalid, 2 read only, 3 not readable.
      test_name = "faults";
      send_req(make_va(1, 'h100), 1'b0);
      send_req(make_va(2, 'h200), 1'b1);
      send_req(make_va(3, 'h300), 1'b0);
      drain();

      test_name = "replace_flush";
      for (int v = 8; v < 13; v++)
      begin
         send_req(make_va(v, int'($urandom_range(0, 4095))), 1'($urandom));
      end
      send_req(make_va(8, 'h044), 1'b0);
      drain();
      flush_tlb();
      send_req(make_va(10, 'h0c0), 1'b0);
      send_req(make_va(11, 'h0d0), 1'b1);
      drain();

      test_name = "bypass";
      active = 1'b0;
      next_cycle();
      repeat (3) send_req({$urandom, $urandom}, 1'($urandom));
      drain();
      active = 1'b1;
      next_cycle();

      test_name = "credit_burst";
      late = 1'b1;
      for (int n = 0; n < N_BURST; n++)
      begin
         vpn = int'($urandom_range(0, 1)) * 64 + int'($urandom_range(0, 15));
         send_req(make_va(vpn, int'($urandom_range(0, 4095))), 1'($urandom));
      end
      drain();
      late = 1'b0;

      if (checker_errors() == 0)
      begin
         $display("TEST PASS");
         $finish;
      end
      else
      begin
         report_error("protocol checker flagged a violation");
      end
   end

endmodule

// File: verif/mmu_chk.sv
`timescale 1ns/10ps

module mmu_chk #(
   parameter int RESP_CREDITS = 2
) (
   input logic clk,
   input logic rst_n,
   input logic req_valid,
   input logic req_credit,
   input logic resp_valid,
   input logic resp_credit,
   input logic walk_start,
   input logic walk_done
);

   int pending;
   int credits;
   int credit_errs = 0;
   int queue_errs  = 0;
   int walk_errs   = 0;

   // requests accepted but not yet popped.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pending <= 0;
      end
      else
      begin
         pending <= pending + (req_valid ? 1 : 0) - (req_credit ? 1 : 0);
      end
   end

   // response credits granted by the consumer and not yet used.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         credits <= RESP_CREDITS;
      end
      else
      begin
         credits <= credits + (resp_credit ? 1 : 0) - (resp_valid ? 1 : 0);
      end
   end

   resp_needs_credit: assert property (
      @(posedge clk) disable iff (!rst_n) resp_valid |-> (credits > 0))
      else
      begin
         $error("resp_valid raised with no response credit left");
         credit_errs++;
      end

   credit_after_accept: assert property (
      @(posedge clk) disable iff (!rst_n) req_credit |-> (pending > 0))
      else
      begin
         $error("req_credit returned with no accepted request queued");
         queue_errs++;
      end

   // one table read, so the walk always takes two cycles.
   walk_two_cycles: assert property (
      @(posedge clk) disable iff (!rst_n) walk_start |-> ##2 walk_done)
      else
      begin
         $error("walk_done did not follow walk_start by two cycles");
         walk_errs++;
      end

endmodule

// File: source/mmu_top.sv
`timescale 1ns/10ps

module mmu_top #(
   parameter int LG_TLB       = 2,
   parameter int LG_PT        = 6,
   parameter int REQ_DEPTH    = 4,
   parameter int RESP_CREDITS = 2
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      active,
   input  logic                      flush,
   input  logic                      req_valid,
   input  logic [mmu_pkg::VA_W-1:0]  req_va,
   input  logic                      req_store,
   output logic                      req_credit,
   output logic                      resp_valid,
   output logic [mmu_pkg::VA_W-1:0]  resp_pa,
   output logic                      resp_fault,
   output logic                      resp_hit,
   input  logic                      resp_credit,
   input  logic                      pt_we,
   input  logic [LG_PT-1:0]          pt_index,
   input  mmu_pkg::pte_t             pt_entry
);

   logic                       tlb_flush;
   logic                       lookup_req;
   logic [mmu_pkg::VA_W-1:0]   lookup_va;
   logic                       refill;
   logic [mmu_pkg::VA_W-1:0]   refill_va;
   mmu_pkg::walk_rsp_t         refill_rsp;
   logic                       tlb_hit;
   logic [mmu_pkg::VA_W-1:0]   tlb_pa;
   logic                       tlb_readable;
   logic                       tlb_writable;
   logic                       walk_start;
   logic [mmu_pkg::VPN_W-1:0]  walk_vpn;
   logic                       walk_done;
   mmu_pkg::walk_rsp_t         walk_rsp;
   logic [LG_PT-1:0]           rd_index;
   mmu_pkg::pte_t              rd_entry;

   xlate_ctrl #(
      .REQ_DEPTH    (REQ_DEPTH),
      .RESP_CREDITS (RESP_CREDITS)
   ) u_ctrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .active       (active),
      .req_valid    (req_valid),
      .req_va       (req_va),
      .req_store    (req_store),
      .req_credit   (req_credit),
      .resp_valid   (resp_valid),
      .resp_pa      (resp_pa),
      .resp_fault   (resp_fault),
      .resp_hit     (resp_hit),
      .resp_credit  (resp_credit),
      .flush_in     (flush),
      .flush        (tlb_flush),
      .lookup_req   (lookup_req),
      .lookup_va    (lookup_va),
      .refill       (refill),
      .refill_va    (refill_va),
      .refill_rsp   (refill_rsp),
      .tlb_hit      (tlb_hit),
      .tlb_pa       (tlb_pa),
      .tlb_readable (tlb_readable),
      .tlb_writable (tlb_writable),
      .walk_start   (walk_start),
      .walk_vpn     (walk_vpn),
      .walk_done    (walk_done),
      .walk_rsp     (walk_rsp)
   );

   // dirty and user are kept per entry but not checked.
   tlb #(.LG_N(LG_TLB)) u_tlb (
      .clk        (clk),
      .rst_n      (rst_n),
      .flush      (tlb_flush),
      .active     (active),
      .lookup_req (lookup_req),
      .lookup_va  (lookup_va),
      .refill     (refill),
      .refill_va  (refill_va),
      .refill_rsp (refill_rsp),
      .hit        (tlb_hit),
      .pa         (tlb_pa),
      .dirty      (),
      .readable   (tlb_readable),
      .writable   (tlb_writable),
      .user       ()
   );

   page_walker #(.LG_PT(LG_PT)) u_walker (
      .clk        (clk),
      .rst_n      (rst_n),
      .walk_start (walk_start),
      .walk_vpn   (walk_vpn),
      .walk_done  (walk_done),
      .walk_rsp   (walk_rsp),
      .rd_index   (rd_index),
      .rd_entry   (rd_entry)
   );

   page_table_ram #(.LG_PT(LG_PT)) u_pt (
      .clk    (clk),
      .we     (pt_we),
      .windex (pt_index),
      .wentry (pt_entry),
      .rindex (rd_index),
      .rentry (rd_entry)
   );

endmodule

// File: source/xlate_ctrl.sv
`timescale 1ns/10ps

module xlate_ctrl #(
   parameter int REQ_DEPTH    = 4,
   parameter int RESP_CREDITS = 2
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       active,
   input  logic                       req_valid,
   input  logic [mmu_pkg::VA_W-1:0]   req_va,
   input  logic                       req_store,
   output logic                       req_credit,
   output logic                       resp_valid,
   output logic [mmu_pkg::VA_W-1:0]   resp_pa,
   output logic                       resp_fault,
   output logic                       resp_hit,
   input  logic                       resp_credit,
   input  logic                       flush_in,
   output logic                       flush,
   output logic                       lookup_req,
   output logic [mmu_pkg::VA_W-1:0]   lookup_va,
   output logic                       refill,
   output logic [mmu_pkg::VA_W-1:0]   refill_va,
   output mmu_pkg::walk_rsp_t         refill_rsp,
   input  logic                       tlb_hit,
   input  logic [mmu_pkg::VA_W-1:0]   tlb_pa,
   input  logic                       tlb_readable,
   input  logic                       tlb_writable,
   output logic                       walk_start,
   output logic [mmu_pkg::VPN_W-1:0]  walk_vpn,
   input  logic                       walk_done,
   input  mmu_pkg::walk_rsp_t         walk_rsp
);

   localparam int PW = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
   localparam int QW = $clog2(REQ_DEPTH + 1);
   localparam int CW = $clog2(RESP_CREDITS + 1);

   logic [mmu_pkg::VA_W-1:0]  q_va [REQ_DEPTH];
   logic                      q_store [REQ_DEPTH];
   logic [PW-1:0]             wr_ptr;
   logic [PW-1:0]             rd_ptr;
   logic [QW-1:0]             q_count;
   logic [CW-1:0]             resp_cnt;
   logic [mmu_pkg::VA_W-1:0]  cur_va;
   logic                      cur_store;
   logic                      walked;
   logic                      pop;
   logic                      perm_fault;
   mmu_ctrl_pkg::ctrl_state_t state;

   assign pop        = (state == mmu_ctrl_pkg::CTRL_IDLE) && (q_count != '0);
   assign req_credit = pop;
   assign resp_valid = (state == mmu_ctrl_pkg::CTRL_RESP) && (resp_cnt != '0);
   assign perm_fault = cur_store ? !tlb_writable : !tlb_readable;

   // first lookup goes out with the pop, the second after the refill.
   assign lookup_req = (pop && active) || (state == mmu_ctrl_pkg::CTRL_REFILL);
   assign lookup_va  = (state == mmu_ctrl_pkg::CTRL_IDLE) ? q_va[rd_ptr] : cur_va;
   assign walk_start = (state == mmu_ctrl_pkg::CTRL_LOOKUP) && !tlb_hit;
   assign walk_vpn   = cur_va[mmu_pkg::PAGE_OFS_W +: mmu_pkg::VPN_W];
   assign refill     = (state == mmu_ctrl_pkg::CTRL_WALK) && walk_done && !walk_rsp.fault;
   assign refill_va  = cur_va;
   assign refill_rsp = walk_rsp;
   assign flush      = flush_in;

   always_ff @(posedge clk)
   begin
      if (req_valid)
      begin
         q_va[wr_ptr]    <= req_va;
         q_store[wr_ptr] <= req_store;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         q_count  <= '0;
         resp_cnt <= CW'(RESP_CREDITS);
      end
      else
      begin
         if (req_valid)
         begin
            wr_ptr <= (wr_ptr == PW'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop)
         begin
            rd_ptr <= (rd_ptr == PW'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({req_valid, pop})
            2'b10:   q_count <= q_count + 1'b1;
            2'b01:   q_count <= q_count - 1'b1;
            default: q_count <= q_count;
         endcase
         case ({resp_credit, resp_valid})
            2'b10:   resp_cnt <= resp_cnt + 1'b1;
            2'b01:   resp_cnt <= resp_cnt - 1'b1;
            default: resp_cnt <= resp_cnt;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state  <= mmu_ctrl_pkg::CTRL_IDLE;
         walked <= 1'b0;
      end
      else
      begin
         unique case (state)
            mmu_ctrl_pkg::CTRL_IDLE:
               if (pop)
               begin
                  walked <= 1'b0;
                  state  <= active ? mmu_ctrl_pkg::CTRL_LOOKUP : mmu_ctrl_pkg::CTRL_RESP;
               end
            mmu_ctrl_pkg::CTRL_LOOKUP:
               state <= tlb_hit ? mmu_ctrl_pkg::CTRL_RESP : mmu_ctrl_pkg::CTRL_WALK;
            mmu_ctrl_pkg::CTRL_WALK:
               if (walk_done)
               begin
                  state <= walk_rsp.fault ? mmu_ctrl_pkg::CTRL_RESP
                                          : mmu_ctrl_pkg::CTRL_REFILL;
               end
            mmu_ctrl_pkg::CTRL_REFILL:
            begin
               walked <= 1'b1;
               state  <= mmu_ctrl_pkg::CTRL_LOOKUP;
            end
            default:
               if (resp_valid)
               begin
                  state <= mmu_ctrl_pkg::CTRL_IDLE;
               end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (pop)
      begin
         cur_va    <= q_va[rd_ptr];
         cur_store <= q_store[rd_ptr];
      end
      if (pop && !active)
      begin
         resp_pa    <= q_va[rd_ptr];
         resp_fault <= 1'b0;
         resp_hit   <= 1'b1;
      end
      if (state == mmu_ctrl_pkg::CTRL_LOOKUP)
      begin
         if (!walked)
         begin
            resp_hit <= tlb_hit;
         end
         if (tlb_hit)
         begin
            resp_fault <= perm_fault;
            resp_pa    <= perm_fault ? '0 : tlb_pa;
         end
      end
      // invalid entry, nothing is refilled.
      if ((state == mmu_ctrl_pkg::CTRL_WALK) && walk_done && walk_rsp.fault)
      begin
         resp_fault <= 1'b1;
         resp_pa    <= '0;
      end
   end

endmodule

// File: source/page_walker.sv
`timescale 1ns/10ps

module page_walker #(
   parameter int LG_PT = 6
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       walk_start,
   input  logic [mmu_pkg::VPN_W-1:0]  walk_vpn,
   output logic                       walk_done,
   output mmu_pkg::walk_rsp_t         walk_rsp,
   output logic [LG_PT-1:0]           rd_index,
   input  mmu_pkg::pte_t              rd_entry
);

   mmu_ctrl_pkg::walk_state_t state;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= mmu_ctrl_pkg::WALK_IDLE;
      end
      else
      begin
         unique case (state)
            mmu_ctrl_pkg::WALK_IDLE:
               if (walk_start)
               begin
                  state <= mmu_ctrl_pkg::WALK_READ;
               end
            mmu_ctrl_pkg::WALK_READ:
               state <= mmu_ctrl_pkg::WALK_DONE;
            default:
               state <= mmu_ctrl_pkg::WALK_IDLE;
         endcase
      end
   end

   // direct-mapped, low page number bits pick the entry.
   always_ff @(posedge clk)
   begin
      if (walk_start)
      begin
         rd_index <= walk_vpn[LG_PT-1:0];
      end
   end

   assign walk_done = (state == mmu_ctrl_pkg::WALK_DONE);

   always_comb
   begin
      walk_rsp       = '0;
      walk_rsp.fault = !rd_entry.valid;
      if (rd_entry.valid)
      begin
         walk_rsp.valid      = 1'b1;
         walk_rsp.dirty      = rd_entry.dirty;
         walk_rsp.readable   = rd_entry.readable;
         walk_rsp.writable   = rd_entry.writable;
         walk_rsp.executable = rd_entry.executable;
         walk_rsp.user       = rd_entry.user;
         walk_rsp.ppn        = rd_entry.ppn;
      end
   end

endmodule

// File: source/page_table_ram.sv
`timescale 1ns/10ps

module page_table_ram #(
   parameter int LG_PT = 6
) (
   input  logic               clk,
   input  logic               we,
   input  logic [LG_PT-1:0]   windex,
   input  mmu_pkg::pte_t      wentry,
   input  logic [LG_PT-1:0]   rindex,
   output mmu_pkg::pte_t      rentry
);

   localparam int DEPTH = 1 << LG_PT;

   mmu_pkg::pte_t mem [DEPTH];

   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[windex] <= wentry;
      end
   end

   // read data follows the address by one cycle.
   always_ff @(posedge clk)
   begin
      rentry <= mem[rindex];
   end

endmodule

// File: source/tlb.sv
`timescale 1ns/10ps

module tlb #(
   parameter int LG_N = 2
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      flush,
   input  logic                      active,
   input  logic                      lookup_req,
   input  logic [mmu_pkg::VA_W-1:0]  lookup_va,
   input  logic                      refill,
   input  logic [mmu_pkg::VA_W-1:0]  refill_va,
   input  mmu_pkg::walk_rsp_t        refill_rsp,
   output logic                      hit,
   output logic [mmu_pkg::VA_W-1:0]  pa,
   output logic                      dirty,
   output logic                      readable,
   output logic                      writable,
   output logic                      user
);

   localparam int N      = 1 << LG_N;
   localparam int PA_PAD = mmu_pkg::VA_W - mmu_pkg::PPN_W - mmu_pkg::PAGE_OFS_W;

   logic [N-1:0]               r_valid;
   logic [N-1:0]               r_dirty;
   logic [N-1:0]               r_readable;
   logic [N-1:0]               r_writable;
   logic [N-1:0]               r_user;
   logic [mmu_pkg::VPN_W-1:0]  r_tag [N];
   logic [mmu_pkg::PPN_W-1:0]  r_ppn [N];
   logic [LG_N-1:0]            r_ptr;
   logic [N-1:0]               match;
   logic [LG_N:0]              ffs_y;
   logic [LG_N-1:0]            sel;

   for (genvar i = 0; i < N; i++)
   begin : g_cmp
      assign match[i] = r_valid[i] &&
                        (r_tag[i] == lookup_va[mmu_pkg::PAGE_OFS_W +: mmu_pkg::VPN_W]);
   end

   find_first_set #(.LG_N(LG_N)) u_ffs (
      .in (match),
      .y  (ffs_y)
   );

   assign sel = ffs_y[LG_N-1:0];

   // inactive mode always hits and passes the address through.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         hit <= 1'b0;
      end
      else
      begin
         hit <= active ? (lookup_req & ffs_y[LG_N]) : 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      pa       <= active ? {{PA_PAD{1'b0}}, r_ppn[sel], lookup_va[mmu_pkg::PAGE_OFS_W-1:0]}
                         : lookup_va;
      dirty    <= r_dirty[sel];
      readable <= r_readable[sel];
      writable <= r_writable[sel];
      user     <= r_user[sel];
   end

   // a refill in the same cycle as a flush still lands.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         r_valid <= '0;
         r_ptr   <= '0;
      end
      else
      begin
         if (flush)
         begin
            r_valid <= '0;
         end
         if (refill)
         begin
            r_valid[r_ptr] <= 1'b1;
            r_ptr          <= r_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (refill)
      begin
         r_tag[r_ptr]      <= refill_va[mmu_pkg::PAGE_OFS_W +: mmu_pkg::VPN_W];
         r_ppn[r_ptr]      <= refill_rsp.ppn;
         r_dirty[r_ptr]    <= refill_rsp.dirty;
         r_readable[r_ptr] <= refill_rsp.readable;
         r_writable[r_ptr] <= refill_rsp.writable;
         r_user[r_ptr]     <= refill_rsp.user;
      end
   end

endmodule

// File: source/find_first_set.sv
`timescale 1ns/10ps

module find_first_set #(
   parameter int LG_N = 2
) (
   input  logic [(1<<LG_N)-1:0] in,
   output logic [LG_N:0]        y
);

   localparam int N = 1 << LG_N;

   // scan from the top so the lowest set bit wins.
   always_comb
   begin
      y = '0;
      for (int i = N - 1; i >= 0; i--)
      begin
         if (in[i])
         begin
            y = {1'b1, LG_N'(i)};
         end
      end
   end

endmodule

// File: source/mmu_ctrl_pkg.sv
package mmu_ctrl_pkg;

   // walker sequence, one table read per walk.
   typedef enum logic [1:0] {
      WALK_IDLE,
      WALK_READ,
      WALK_DONE
   } walk_state_t;

   // translation sequence for the request at the queue head.
   typedef enum logic [2:0] {
      CTRL_IDLE,
      CTRL_LOOKUP,
      CTRL_WALK,
      CTRL_REFILL,
      CTRL_RESP
   } ctrl_state_t;

endpackage

// File: source/mmu_pkg.sv
package mmu_pkg;

   // virtual address layout.
   localparam int VA_W       = 64;
   localparam int PAGE_OFS_W = 12;
   // page number is va[39:12].
   localparam int VPN_W      = 28;
   localparam int PPN_W      = 28;

   // one page-table entry.
   typedef struct packed {
      logic             valid;
      logic             dirty;
      logic             readable;
      logic             writable;
      logic             executable;
      logic             user;
      logic [PPN_W-1:0] ppn;
   } pte_t;

   // result of a table walk, entry fields plus a fault flag.
   typedef struct packed {
      logic             fault;
      logic             valid;
      logic             dirty;
      logic             readable;
      logic             writable;
      logic             executable;
      logic             user;
      logic [PPN_W-1:0] ppn;
   } walk_rsp_t;

endpackage
